// ==== verilog/forest_cfg.svh ====
`ifndef FOREST_CFG_SVH
`define FOREST_CFG_SVH

// feature and record geometry
`define FEAT_W     32        // single precision float
`define NUM_FEAT   4         // tmax tmin precip wind
`define NUM_DAYS   16        // data set 1
`define DAY_W      4         // day index bits

// forest shape
`define NUM_TREES  3
`define CLASS_W    3         // weather class code width

// split thresholds as raw ieee-754 patterns
`define THR_TMAX_COLD    32'h40A0_0000   // 5.0
`define THR_TMIN_FREEZE  32'h0000_0000   // 0.0
`define THR_PREC_ANY     32'h0000_0000   // 0.0
`define THR_PREC_LIGHT   32'h3F00_0000   // 0.5
`define THR_PREC_MID     32'h3F80_0000   // 1.0
`define THR_PREC_SNOW    32'h4000_0000   // 2.0
`define THR_WIND_BREEZE  32'h4090_0000   // 4.5
`define THR_WIND_STRONG  32'h40A0_0000   // 5.0

`endif

// ==== verilog/weather_pkg.sv ====
`default_nettype none

`include "forest_cfg.svh"

package weather_pkg;

  // one raw float feature
  typedef logic [`FEAT_W-1:0] feature_t;

  // record address into the day table
  typedef logic [`DAY_W-1:0] day_idx_t;

  // class codes as used by the labels of the data set
  typedef enum logic [`CLASS_W-1:0] {
    NONE    = 3'd0,  // reset / idle value
    DRIZZLE = 3'd1,
    FOG     = 3'd2,  // never voted by the three trees
    RAIN    = 3'd3,
    SNOW    = 3'd4,
    SUN     = 3'd5
  } weather_class_e;

  // one day, features in table order plus known class
  typedef struct packed {
    feature_t       temp_max;  // deg c
    feature_t       temp_min;  // deg c
    feature_t       precip;    // mm
    feature_t       wind;      // m/s
    weather_class_e label;     // ground truth
  } day_record_t;              // 131 bits

endpackage

`default_nettype wire

// ==== verilog/forest_pkg.sv ====
`default_nettype none

`include "forest_cfg.svh"

package forest_pkg;

  // one class code per tree, tree 0 in the low slot
  typedef weather_pkg::weather_class_e [`NUM_TREES-1:0] tree_votes_t;

  // what the vote stage sees each cycle
  typedef struct packed {
    tree_votes_t                 votes;  // registered tree outputs
    weather_pkg::weather_class_e label;  // known class, delayed to match
    logic                        valid;  // item present this cycle
  } vote_stage_t;

endpackage

`default_nettype wire

// ==== verilog/day_record_rom.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "forest_cfg.svh"

module day_record_rom (
  input  logic                     clock_50,
  input  logic                     rst,
  input  logic                     sample,       // one cycle strobe
  input  weather_pkg::day_idx_t    day_sel,      // valid with sample
  output weather_pkg::day_record_t record,
  output logic                     record_valid  // one cycle after sample
);

  weather_pkg::day_record_t rom_rec;  // addressed entry, comb

  // table is fully decoded, one entry per index value
  if (`NUM_DAYS != (1 << `DAY_W)) begin : g_bad_days
    $error("day table size does not match index width");
  end
  if ($bits(weather_pkg::day_record_t) != `NUM_FEAT * `FEAT_W + `CLASS_W) begin : g_bad_rec
    $error("record width does not match feature count");
  end

  // data set 1, fields are tmax tmin precip wind label
  always_comb begin
    case (day_sel)
      4'd0:  rom_rec = '{32'h414C_CCCD, 32'h40A0_0000, 32'h0000_0000, 32'h4096_6666,
                         weather_pkg::DRIZZLE};  // 12.8 5.0 0.0 4.7
      4'd1:  rom_rec = '{32'h4129_999A, 32'h4033_3333, 32'h412E_6666, 32'h4090_0000,
                         weather_pkg::RAIN};     // 10.6 2.8 10.9 4.5
      4'd2:  rom_rec = '{32'h4120_0000, 32'h4033_3333, 32'h0000_0000, 32'h4000_0000,
                         weather_pkg::SUN};      // 10.0 2.8 0.0 2.0
      4'd3:  rom_rec = '{32'h413B_3333, 32'h40E6_6666, 32'h3F4C_CCCD, 32'h4013_3333,
                         weather_pkg::RAIN};     // 11.7 7.2 0.8 2.3
      4'd4:  rom_rec = '{32'h408C_CCCD, 32'h3F19_999A, 32'h4083_3333, 32'h40A9_999A,
                         weather_pkg::SNOW};     // 4.4 0.6 4.1 5.3
      4'd5:  rom_rec = '{32'h410E_6666, 32'h4033_3333, 32'h3FA6_6666, 32'h40C3_3333,
                         weather_pkg::RAIN};     // 8.9 2.8 1.3 6.1
      4'd6:  rom_rec = '{32'h40C3_3333, 32'hBF8C_CCCD, 32'h0000_0000, 32'h40A3_3333,
                         weather_pkg::SUN};      // 6.1 -1.1 0.0 5.1
      4'd7:  rom_rec = '{32'h3F8C_CCCD, 32'hC053_3333, 32'h40A9_999A, 32'h404C_CCCD,
                         weather_pkg::SNOW};     // 1.1 -3.3 5.3 3.2
      4'd8:  rom_rec = '{32'h40E6_6666, 32'h4033_3333, 32'h0000_0000, 32'h4013_3333,
                         weather_pkg::RAIN};     // 7.2 2.8 0.0 2.3
      4'd9:  rom_rec = '{32'h40C3_3333, 32'hBFD9_999A, 32'h0000_0000, 32'h3FF3_3333,
                         weather_pkg::SUN};      // 6.1 -1.7 0.0 1.9
      4'd10: rom_rec = '{32'h3FD9_999A, 32'hC033_3333, 32'h4020_0000, 32'h40A0_0000,
                         weather_pkg::SNOW};     // 1.7 -2.8 2.5 5.0
      4'd11: rom_rec = '{32'h4143_3333, 32'h40B3_3333, 32'h41A2_6666, 32'h4096_6666,
                         weather_pkg::RAIN};     // 12.2 5.6 20.3 4.7
      4'd12: rom_rec = '{32'h40A0_0000, 32'hC033_3333, 32'h0000_0000, 32'h3FA6_6666,
                         weather_pkg::SUN};      // 5.0 -2.8 0.0 1.3
      4'd13: rom_rec = '{32'h4116_6666, 32'h40A0_0000, 32'h4089_999A, 32'h4059_999A,
                         weather_pkg::RAIN};     // 9.4 5.0 4.3 3.4
      4'd14: rom_rec = '{32'h40C3_3333, 32'h3F19_999A, 32'h3F80_0000, 32'h4059_999A,
                         weather_pkg::RAIN};     // 6.1 0.6 1.0 3.4
      4'd15: rom_rec = '{32'h408C_CCCD, 32'h400C_CCCD, 32'h4020_0000, 32'h400C_CCCD,
                         weather_pkg::RAIN};     // 4.4 2.2 2.5 2.2
    endcase
  end

  // record only moves on a strobe
  always_ff @(posedge clock_50) begin
    if (sample)
      record <= rom_rec;
  end

  always_ff @(posedge clock_50) begin
    if (rst)
      record_valid <= 1'b0;
    else
      record_valid <= sample;  // single cycle marker
  end

  // address must be clean whenever it is used
  a_sel_known: assert property (@(posedge clock_50) disable iff (rst)
    sample |-> !$isunknown(day_sel));

endmodule

`default_nettype wire

// ==== verilog/decision_tree.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "forest_cfg.svh"

module decision_tree #(
  parameter int TREE_ID = 0  // picks the split set
) (
  input  logic                        clock_50,
  input  logic                        rst,
  input  weather_pkg::day_record_t    record,
  output weather_pkg::weather_class_e vote
);

  // three distinct split sets, higher ids reuse them in turn
  localparam int RULE = TREE_ID % 3;

  weather_pkg::weather_class_e next_vote;

  // strict a > b on raw floats
  // sign first then magnitude, +0 and -0 equal, no nan in the table
  function automatic logic fp_gt(input weather_pkg::feature_t a,
                                 input weather_pkg::feature_t b);
    logic a_zero;
    logic b_zero;
    logic gt;
    a_zero = (a[`FEAT_W-2:0] == '0);
    b_zero = (b[`FEAT_W-2:0] == '0);
    if (a_zero && b_zero)
      gt = 1'b0;
    else if (a[`FEAT_W-1] != b[`FEAT_W-1])
      gt = !a[`FEAT_W-1];                   // positive side wins
    else if (!a[`FEAT_W-1])
      gt = a[`FEAT_W-2:0] > b[`FEAT_W-2:0]; // both positive
    else
      gt = a[`FEAT_W-2:0] < b[`FEAT_W-2:0]; // both negative, order flips
    return gt;
  endfunction

  // two level split per tree
  always_comb begin
    next_vote = weather_pkg::SUN;
    case (RULE)
      0: begin
        if (fp_gt(record.precip, `THR_PREC_ANY)) begin        // wet day
          if (fp_gt(`THR_TMAX_COLD, record.temp_max))
            next_vote = weather_pkg::SNOW;
          else
            next_vote = weather_pkg::RAIN;
        end else if (fp_gt(record.wind, `THR_WIND_BREEZE))    // dry and windy
          next_vote = weather_pkg::DRIZZLE;
        else
          next_vote = weather_pkg::SUN;
      end
      1: begin
        if (fp_gt(`THR_TMIN_FREEZE, record.temp_min)) begin   // frost night
          if (fp_gt(record.precip, `THR_PREC_SNOW))
            next_vote = weather_pkg::SNOW;
          else
            next_vote = weather_pkg::SUN;
        end else if (fp_gt(record.precip, `THR_PREC_LIGHT))
          next_vote = weather_pkg::RAIN;
        else
          next_vote = weather_pkg::DRIZZLE;
      end
      default: begin
        if (fp_gt(record.wind, `THR_WIND_STRONG)) begin       // stormy
          if (fp_gt(`THR_TMAX_COLD, record.temp_max))
            next_vote = weather_pkg::SNOW;
          else
            next_vote = weather_pkg::DRIZZLE;
        end else if (fp_gt(record.precip, `THR_PREC_MID))
          next_vote = weather_pkg::RAIN;
        else
          next_vote = weather_pkg::SUN;
      end
    endcase
  end

  // vote lands one cycle after the record
  always_ff @(posedge clock_50) begin
    if (rst)
      vote <= weather_pkg::NONE;
    else
      vote <= next_vote;
  end

endmodule

`default_nettype wire

// ==== verilog/majority_vote.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "forest_cfg.svh"

module majority_vote (
  input  logic                        clock_50,
  input  logic                        rst,
  input  forest_pkg::vote_stage_t     stage,
  output weather_pkg::weather_class_e estimate,
  output weather_pkg::weather_class_e label,
  output logic                        est_valid
);

  localparam int NUM_CLASS = 1 << `CLASS_W;       // every code gets a counter
  localparam int CNT_W     = $clog2(`NUM_TREES + 1);

  logic [CNT_W-1:0]            cnt [NUM_CLASS];  // votes per class
  logic [CNT_W-1:0]            best_cnt;
  weather_pkg::weather_class_e winner;

  always_comb begin
    for (int c = 0; c < NUM_CLASS; c++) begin
      cnt[c] = '0;
      for (int t = 0; t < `NUM_TREES; t++) begin
        if (int'(stage.votes[t]) == c)
          cnt[c] = cnt[c] + CNT_W'(1);
      end
    end
    // start from tree 0, only a strictly larger count replaces it
    winner   = stage.votes[0];
    best_cnt = cnt[stage.votes[0]];
    for (int c = 0; c < NUM_CLASS; c++) begin
      if (cnt[c] > best_cnt) begin
        winner   = weather_pkg::weather_class_e'(c);
        best_cnt = cnt[c];
      end
    end
  end

  // outputs read NONE between results
  always_ff @(posedge clock_50) begin
    if (rst) begin
      est_valid <= 1'b0;
      estimate  <= weather_pkg::NONE;
      label     <= weather_pkg::NONE;
    end else begin
      est_valid <= stage.valid;        // one pulse per item
      if (stage.valid) begin
        estimate <= winner;
        label    <= stage.label;       // rides along unchanged
      end else begin
        estimate <= weather_pkg::NONE;
        label    <= weather_pkg::NONE;
      end
    end
  end

  // trees never vote NONE once a real record is behind them
  a_est_class: assert property (@(posedge clock_50) disable iff (rst)
    est_valid |-> estimate != weather_pkg::NONE);

endmodule

`default_nettype wire

// ==== verilog/weather_forest.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "forest_cfg.svh"

module weather_forest (
  input  logic                        clock_50,
  input  logic                        rst,
  input  logic                        sample,   // new record request
  input  weather_pkg::day_idx_t       day_sel,
  output logic                        est_valid,
  output weather_pkg::weather_class_e estimate,
  output weather_pkg::weather_class_e label     // known answer for estimate
);

  weather_pkg::day_record_t    rec;        // rom output, stage 1
  logic                        rec_valid;
  forest_pkg::tree_votes_t     votes;      // stage 2
  weather_pkg::weather_class_e label_q;    // label aligned with votes
  logic                        valid_q;
  forest_pkg::vote_stage_t     stage;

  day_record_rom u_rom (
    .clock_50     (clock_50),
    .rst          (rst),
    .sample       (sample),
    .day_sel      (day_sel),
    .record       (rec),
    .record_valid (rec_valid)
  );

  for (genvar t = 0; t < `NUM_TREES; t++) begin : g_tree
    decision_tree #(.TREE_ID(t)) u_tree (
      .clock_50 (clock_50),
      .rst      (rst),
      .record   (rec),
      .vote     (votes[t])
    );
  end

  // match the tree register stage
  always_ff @(posedge clock_50) begin
    if (rst)
      valid_q <= 1'b0;
    else
      valid_q <= rec_valid;
  end

  always_ff @(posedge clock_50) begin
    label_q <= rec.label;  // class of the record now in the trees
  end

  always_comb begin
    stage.votes = votes;
    stage.label = label_q;
    stage.valid = valid_q;
  end

  majority_vote u_vote (
    .clock_50  (clock_50),
    .rst       (rst),
    .stage     (stage),
    .estimate  (estimate),
    .label     (label),
    .est_valid (est_valid)
  );

  // three stage latency and an item hit by reset never comes out
  a_latency: assert property (@(posedge clock_50) disable iff (rst)
    est_valid == ($past(sample, 3) && !$past(rst, 3) && !$past(rst, 2) && !$past(rst, 1)));

endmodule

`default_nettype wire

// ==== sim/tb_weather_forest.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "forest_cfg.svh"

module tb_weather_forest;

  localparam int LATENCY    = 3;   // drive edge to est_valid
  localparam int WAIT_LIMIT = 40;  // cycles before a wait gives up
  localparam int GAP_ITEMS  = 12;

  logic                        clock_50;
  logic                        rst;
  logic                        sample;
  weather_pkg::day_idx_t       day_sel;
  logic                        est_valid;
  weather_pkg::weather_class_e estimate;
  weather_pkg::weather_class_e label;

  weather_pkg::weather_class_e case_est [`NUM_DAYS];  // expected estimate from the case file
  weather_pkg::weather_class_e case_lbl [`NUM_DAYS];

  weather_pkg::day_idx_t       exp_day [$];  // samples in drive order
  int                          exp_cyc [$];  // edge count when each sample lands
  weather_pkg::weather_class_e res_est [$];  // results as they pulse out
  weather_pkg::weather_class_e res_lbl [$];
  int                          res_cyc [$];

  int          cyc;           // rising edges so far
  logic [31:0] rng;           // lcg state
  int          err_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;

  weather_forest UUT (
    .clock_50  (clock_50),
    .rst       (rst),
    .sample    (sample),
    .day_sel   (day_sel),
    .est_valid (est_valid),
    .estimate  (estimate),
    .label     (label)
  );

  initial begin
    clock_50 = 1'b0;
    forever #2 clock_50 = ~clock_50;  // 4 ns period
  end

  always @(posedge clock_50) cyc <= cyc + 1;

  // grab each result at the falling edge once outputs have settled
  always @(negedge clock_50) begin
    if (est_valid === 1'b1) begin
      res_est.push_back(estimate);
      res_lbl.push_back(label);
      res_cyc.push_back(cyc);
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // numerical recipes constants
  endfunction

  function automatic int rand_below(input int range);
    rng = lcg_step(rng);
    return int'(rng[30:16]) % range;  // upper bits as the low ones cycle fast
  endfunction

  // unknown shows up as -1 so it never matches a class
  function automatic int class_code(input logic [`CLASS_W-1:0] c);
    return $isunknown(c) ? -1 : int'(c);
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      err_count++;
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          loaded;
    string       line;
    logic [31:0] f_day;
    logic [31:0] f_est;
    logic [31:0] f_lbl;
    loaded = 0;
    fd = $fopen("sim/weather_cases.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("could not open sim/weather_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#") begin     // skip column notes
        if ($sscanf(line, "%d %d %d", f_day, f_est, f_lbl) == 3) begin
          case_est[f_day[`DAY_W-1:0]] = weather_pkg::weather_class_e'(f_est[`CLASS_W-1:0]);
          case_lbl[f_day[`DAY_W-1:0]] = weather_pkg::weather_class_e'(f_lbl[`CLASS_W-1:0]);
          loaded++;
        end
      end
    end
    $fclose(fd);
    if (loaded != `NUM_DAYS) begin
      err_count++;
      $display("case file gave %0d days where %0d were needed", loaded, `NUM_DAYS);
    end
  endtask

  task automatic clear_queues();
    exp_day.delete();
    exp_cyc.delete();
    res_est.delete();
    res_lbl.delete();
    res_cyc.delete();
  endtask

  task automatic drive_sample(input weather_pkg::day_idx_t d);
    @(posedge clock_50);
    sample  <= 1'b1;
    day_sel <= d;
    exp_day.push_back(d);
    exp_cyc.push_back(cyc + 1);  // cyc still holds the count before this edge
  endtask

  task automatic drive_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clock_50);
      sample <= 1'b0;
    end
  endtask

  // polled on rising edges while the monitor pushes on falling ones
  task automatic wait_results(input string test, input int count);
    int waited;
    waited = 0;
    while (res_est.size() < count && waited < WAIT_LIMIT) begin
      @(posedge clock_50);
      waited++;
    end
    if (res_est.size() < count) begin
      err_count++;
      $display("timeout in %s, only %0d of %0d results came out",
               test, res_est.size(), count);
    end
  endtask

  // outputs idle for a number of cycles
  task automatic watch_quiet(input string test, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clock_50);
      check_value({test, " est_valid"}, 0, int'(est_valid !== 1'b0));
      check_value({test, " estimate"}, int'(weather_pkg::NONE), class_code(estimate));
      check_value({test, " label"}, int'(weather_pkg::NONE), class_code(label));
    end
  endtask

  task automatic match_results(input string test);
    int    n;
    string tag;
    check_value({test, " result count"}, exp_day.size(), res_est.size());
    n = (res_est.size() < exp_day.size()) ? res_est.size() : exp_day.size();
    for (int i = 0; i < n; i++) begin
      tag = $sformatf("%s item %0d day %0d", test, i, exp_day[i]);
      check_value({tag, " estimate"}, int'(case_est[exp_day[i]]), class_code(res_est[i]));
      check_value({tag, " label"}, int'(case_lbl[exp_day[i]]), class_code(res_lbl[i]));
      check_value({tag, " latency"}, LATENCY, res_cyc[i] - exp_cyc[i]);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic idle_after_reset();
    int errs;
    errs = err_count;
    watch_quiet("reset_idle", 8);
    check_value("reset_idle pulses", 0, res_est.size());
    end_test("reset_idle", errs);
  endtask

  task automatic single_day(input weather_pkg::day_idx_t d);
    int    errs;
    string name;
    errs = err_count;
    name = $sformatf("single_day_%0d", d);
    clear_queues();
    drive_sample(d);
    drive_idle(1);
    wait_results(name, 1);
    watch_quiet(name, 2);  // pulse is one cycle wide
    match_results(name);
    end_test(name, errs);
  endtask

  task automatic back_to_back_burst();
    weather_pkg::day_idx_t order [`NUM_DAYS];
    weather_pkg::day_idx_t tmp;
    int                    j;
    int                    errs;
    errs = err_count;
    clear_queues();
    for (int i = 0; i < `NUM_DAYS; i++)
      order[i] = weather_pkg::day_idx_t'(i);
    for (int i = `NUM_DAYS - 1; i > 0; i--) begin  // fisher-yates
      j        = rand_below(i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[i])
      drive_sample(order[i]);  // one per edge without gaps
    drive_idle(1);
    wait_results("back_to_back", `NUM_DAYS);
    watch_quiet("back_to_back", 2);
    match_results("back_to_back");
    for (int i = 1; i < res_cyc.size(); i++)
      check_value($sformatf("back_to_back spacing %0d", i), 1, res_cyc[i] - res_cyc[i-1]);
    end_test("back_to_back", errs);
  endtask

  task automatic random_gap_stream();
    int errs;
    errs = err_count;
    clear_queues();
    for (int i = 0; i < GAP_ITEMS; i++) begin
      drive_sample(weather_pkg::day_idx_t'(rand_below(`NUM_DAYS)));
      drive_idle(rand_below(5));  // zero gap keeps the next sample adjacent
    end
    drive_idle(1);
    wait_results("random_gaps", GAP_ITEMS);
    watch_quiet("random_gaps", 4);  // no late extra pulse
    match_results("random_gaps");
    end_test("random_gaps", errs);
  endtask

  task automatic reset_in_flight();
    int errs;
    errs = err_count;
    clear_queues();
    drive_sample(4'd7);
    drive_sample(4'd1);
    @(posedge clock_50);
    sample <= 1'b0;
    rst    <= 1'b1;  // both items still inside the pipe
    repeat (2) @(posedge clock_50);
    rst <= 1'b0;
    watch_quiet("reset_flight", 8);
    check_value("reset_flight pulses", 0, res_est.size());
    end_test("reset_flight", errs);
  endtask

  initial begin
    rst          = 1'b1;
    sample       = 1'b0;
    day_sel      = '0;
    cyc          = 0;
    rng          = 32'ha0c9_8111;
    err_count    = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_cases();
    repeat (5) @(posedge clock_50);  // reset for five edges
    rst <= 1'b0;
    idle_after_reset();
    for (int d = 0; d < `NUM_DAYS; d++)
      single_day(weather_pkg::day_idx_t'(d));
    back_to_back_burst();
    random_gap_stream();
    reset_in_flight();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/weather_pkg.sv
verilog/forest_pkg.sv
verilog/day_record_rom.sv
verilog/decision_tree.sv
verilog/majority_vote.sv
verilog/weather_forest.sv
sim/tb_weather_forest.sv

// ==== run_sim.sh ====
#!/bin/sh
# build forest and testbench with verilator, run, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_weather_forest -o tb_sim -f flist.f \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^SIMULATION PASSED$" && echo "run passed" \
  || { echo "run failed"; exit 1; }

// ==== sim/weather_cases.txt ====
# day  estimate  label   (decimal class codes)
# 0 none, 1 drizzle, 2 fog, 3 rain, 4 snow, 5 sun
0  1  1
1  3  3
2  5  5
3  3  3
4  4  4
5  3  3
6  1  5
7  4  4
8  5  3
9  5  5
10 4  4
11 3  3
12 5  5
13 3  3
14 3  3
15 3  3
